/* sources.f */
+incdir+src
src/keypad_pkg.sv
src/word_pkg.sv
src/key_debounce.sv
src/keypad_fsm.sv
src/credit_fifo.sv
src/word_assembler.sv
src/keypad_word_top.sv
sim/keypad_word_properties.sv
sim/keypad_word_tb.sv

/* Makefile */
TOP := keypad_word_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

/* sim/keypad_word_tb.sv */
`timescale 1ns/1ps

`include "keypad_defs.svh"

module keypad_word_tb
  import keypad_pkg::*;
  import word_pkg::*;
();

  localparam int press_len    = 2 * `DEBOUNCE_CYCLES + 2; // Hold, then release as long
  localparam int wait_cycles  = 4 * press_len;            // Word latency bound
  localparam int n_tests      = 5;
  localparam int press_budget = 50;                       // Presses per test, worst case

  logic        clk = 1'b0;
  logic        nRst;
  key_code_t   raw_key;
  logic        word_pop;
  logic        word_valid;
  word_t       word;
  logic        game_over;
  logic [15:0] lfsr_q = 16'd58502;
  int          errors, test_errs, n_run, n_failed;

  keypad_word_top i_dut (.clk, .nRst, .raw_key, .word_pop, .word_valid, .word, .game_over);

  always #50 clk = ~clk; // 100 ns period

  // Galois LFSR, one step per bit
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int b = 0; b < n; b++) begin
      v = (v << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // Letter keys in order A D G J M P T W
  function automatic key_code_t letter_key(input int i);
    int pos; // Grid position row*4+col
    pos = (i < 2) ? i + 1 : (i < 5) ? i + 2 : i + 3;
    return '{row: 4'b1000 >> (pos / 4), col: 4'b1000 >> (pos % 4)};
  endfunction

  function automatic logic [7:0] exp_char(input int i, input int taps);
    int n_letters;
    n_letters = ((i == 5) || (i == 7)) ? 4 : 3;  // PQRS and WXYZ
    return 8'("A" + 3 * i + ((i > 5) ? 1 : 0) + (taps - 1) % n_letters);
  endfunction

  // Append with truncation at MAX_WORD_LEN
  function automatic word_t add_letter(input word_t w, input logic [7:0] ch);
    if (w.len < 4'(`MAX_WORD_LEN)) begin
      w.chars[int'(w.len)] = ch;
      w.len = w.len + 1'b1;
    end
    return w;
  endfunction

  task automatic show_error(input string name, input int got, input int exp);
    $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic hold(input key_code_t code, input int cycles);
    @(posedge clk);
    raw_key <= code;
    repeat (cycles - 1) @(posedge clk);
  endtask

  task automatic press(input key_code_t code);
    hold(code, press_len);
    hold('0, press_len); // Release must settle too
  endtask

  task automatic enter_letter(input int i, input int taps);
    repeat (taps) press(letter_key(i));
    press(key_submit_letter);
  endtask

  task automatic expect_word(input word_t exp);
    int t;
    t = 0;
    @(negedge clk);
    while (!word_valid && (t < wait_cycles)) begin
      @(negedge clk);
      t++;
    end
    if (!word_valid) begin
      $display("No word came out within %0d cycles at %0t", wait_cycles, $time);
      errors++;
      return;
    end
    assert (word.len == exp.len) else show_error("word.len", word.len, exp.len);
    for (int i = 0; i < `MAX_WORD_LEN; i++) begin
      assert (word.chars[i] == exp.chars[i])
        else show_error($sformatf("word.chars[%0d]", i), word.chars[i], exp.chars[i]);
    end
    @(posedge clk);
    word_pop <= 1'b1;
    @(posedge clk);
    word_pop <= 1'b0;
  endtask

  task automatic end_test(input string name);
    n_run++;
    if (errors == test_errs) begin
      $display("%s: ok", name);
    end else begin
      n_failed++;
      $display("%s: FAILED with %0d errors", name, errors - test_errs);
    end
    test_errs = errors;
  endtask

  task automatic test_single();
    for (int i = 0; i < 8; i++) begin
      enter_letter(i, 1);
      press(key_submit_word);
      expect_word(add_letter('0, exp_char(i, 1)));
    end
    end_test("single press");
  endtask

  task automatic test_multitap();
    word_t w;
    int    i, j, taps;
    w = '0;
    repeat (4) begin
      i    = rand_bits(3);
      taps = rand_bits(3) + 1;        // 1 to 8 taps
      enter_letter(i, taps);
      w = add_letter(w, exp_char(i, taps));
    end
    i = rand_bits(3);
    j = (i + 1 + rand_bits(2)) % 8;   // Always a different key
    repeat (2) press(letter_key(i));
    enter_letter(j, 1);               // Restarts at the new base
    w = add_letter(w, exp_char(j, 1));
    press(key_submit_word);
    expect_word(w);
    end_test("multi-tap");
  endtask

  task automatic test_clear_ignore();
    press(letter_key(0));
    press(key_clear);
    press(key_submit_letter);         // Nothing pending now
    press(letter_key(6));
    press(key_ign_r0c0);
    press(key_ign_r0c3);
    press(key_ign_r1c3);
    hold(letter_key(1), `DEBOUNCE_CYCLES - 1); // Glitch, too short
    hold('0, press_len);
    press(key_ign_r3c3);              // Pending T survives
    press(key_submit_letter);
    press(key_submit_word);
    expect_word(add_letter('0, exp_char(6, 1)));
    press(key_submit_word);
    expect_word('0);                  // Empty word
    end_test("clear and ignored keys");
  endtask

  task automatic test_trunc_backpressure();
    word_t w;
    w = '0;
    for (int k = 0; k < `MAX_WORD_LEN + 2; k++) begin
      enter_letter(k % 8, 1);
      w = add_letter(w, exp_char(k % 8, 1));
    end
    press(key_submit_word);
    expect_word(w);
    // Word queue fills, third word stalls in the assembler
    for (int k = 0; k < `WORD_FIFO_DEPTH + 1; k++) begin
      enter_letter(k + 3, 1);
      press(key_submit_word);
    end
    for (int k = 0; k < `WORD_FIFO_DEPTH + 1; k++)
      expect_word(add_letter('0, exp_char(k + 3, 1)));
    end_test("truncation and back-pressure");
  endtask

  task automatic test_game_end();
    int t;
    enter_letter(0, 1);               // Queued in the partial word
    press(letter_key(1));             // Pending in the decoder
    press(key_game_end);
    t = 0;
    @(negedge clk);
    while (!game_over && (t < wait_cycles)) begin
      @(negedge clk);
      t++;
    end
    assert (game_over == 1'b1) else show_error("game_over", game_over, 1);
    enter_letter(2, 1);
    press(key_submit_word);
    for (int c = 0; c < wait_cycles; c++) begin
      @(negedge clk);
      assert (!word_valid) else begin
        $display("A word came out after game end at %0t", $time);
        errors++;
        break;
      end
    end
    end_test("game end");
  endtask

  // Watchdog sized from the test count and press length
  initial begin
    #(n_tests * press_budget * 2 * press_len * 100);
    $display("Run stopped by the watchdog, tests did not finish");
    $display("sim failed");
    $finish;
  end

  initial begin
    nRst      = 1'b0;
    raw_key   = '0;
    word_pop  = 1'b0;
    errors    = 0;
    test_errs = 0;
    n_run     = 0;
    n_failed  = 0;
    repeat (3) @(posedge clk);
    nRst <= 1'b1;
    test_single();
    test_multitap();
    test_clear_ignore();
    test_trunc_backpressure();
    test_game_end();
    errors += i_dut.i_fsm.i_props.n_fail; // Bound decoder assertions
    $display("Tests run %0d, failed %0d, errors %0d", n_run, n_failed, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

/* sim/keypad_word_properties.sv */
`timescale 1ns/1ps

`include "keypad_defs.svh"

module keypad_word_properties
  import word_pkg::*;
(
  input logic                 clk,
  input logic                 nRst,
  input logic                 evt_push,
  input letter_evt_t          evt,
  input logic                 evt_credit,
  input logic [`CREDIT_W-1:0] credit_q
);

  logic [`CREDIT_W-1:0] in_flight; // Pushed events not yet credited back
  int                   n_fail = 0;

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + `CREDIT_W'(evt_push) - `CREDIT_W'(evt_credit);
    end
  end

  // Event queue never overflows
  property push_needs_credit;
    @(posedge clk) disable iff (!nRst)
      evt_push |-> (in_flight < `CREDIT_W'(`EVT_FIFO_DEPTH));
  endproperty

  // Credits returned never exceed the queue depth
  property credit_in_range;
    @(posedge clk) disable iff (!nRst) credit_q <= `CREDIT_W'(`EVT_FIFO_DEPTH);
  endproperty

  // Letters leave the decoder as upper case ASCII
  property letter_is_upper;
    @(posedge clk) disable iff (!nRst)
      (evt_push && (evt.kind == evt_letter)) |-> ((evt.ch >= "A") && (evt.ch <= "Z"));
  endproperty

  a_push_credit: assert property (push_needs_credit)
    else begin
      $error("evt_push with no credit");
      n_fail++;
    end
  a_credit_max: assert property (credit_in_range)
    else begin
      $error("Credit count above depth");
      n_fail++;
    end
  a_letter_az: assert property (letter_is_upper)
    else begin
      $error("Letter event outside A to Z");
      n_fail++;
    end

endmodule

bind keypad_fsm keypad_word_properties i_props (
  .clk, .nRst, .evt_push, .evt, .evt_credit, .credit_q
);

/* src/keypad_word_top.sv */
`timescale 1ns/1ps

`include "keypad_defs.svh"

module keypad_word_top
  import keypad_pkg::*;
  import word_pkg::*;
(
  input  logic      clk,
  input  logic      nRst,
  input  key_code_t raw_key,
  input  logic      word_pop,
  output logic      word_valid,
  output word_t     word,
  output logic      game_over
);

  key_code_t   db_key;      // Stable code
  logic        db_strobe;
  logic        evt_push;
  letter_evt_t evt;
  logic        evt_credit;
  logic        evt_q_valid;
  letter_evt_t evt_q;       // Event queue head
  logic        evt_q_pop;
  logic        word_push;
  word_t       word_in;
  logic        word_credit;

  key_debounce i_debounce (
    .clk, .nRst, .raw_key, .key(db_key), .strobe(db_strobe)
  );

  keypad_fsm i_fsm (
    .clk, .nRst, .key(db_key), .strobe(db_strobe),
    .evt_push, .evt, .evt_credit
  );

  credit_fifo #(.payload_t(letter_evt_t), .depth(`EVT_FIFO_DEPTH)) i_evt_fifo (
    .clk, .nRst, .push(evt_push), .din(evt), .credit_out(evt_credit),
    .valid(evt_q_valid), .dout(evt_q), .pop(evt_q_pop)
  );

  word_assembler i_assembler (
    .clk, .nRst, .evt_valid(evt_q_valid), .evt(evt_q), .evt_pop(evt_q_pop),
    .word_push, .word_in, .word_credit, .game_over
  );

  // Outside reader pops directly, credits unused past here
  credit_fifo #(.payload_t(word_t), .depth(`WORD_FIFO_DEPTH)) i_word_fifo (
    .clk, .nRst, .push(word_push), .din(word_in), .credit_out(word_credit),
    .valid(word_valid), .dout(word), .pop(word_pop)
  );

endmodule

/* src/word_assembler.sv */
`timescale 1ns/1ps

`include "keypad_defs.svh"

module word_assembler
  import word_pkg::*;
(
  input  logic        clk,
  input  logic        nRst,
  input  logic        evt_valid,
  input  letter_evt_t evt,
  output logic        evt_pop,
  output logic        word_push,
  output word_t       word_in,
  input  logic        word_credit,
  output logic        game_over
);

  localparam int idx_w = $clog2(`MAX_WORD_LEN);
  localparam logic [3:0] len_max = `MAX_WORD_LEN;
  localparam logic [`CREDIT_W-1:0] credit_init = `WORD_FIFO_DEPTH;

  logic [3:0]                    len_q;
  logic [`MAX_WORD_LEN-1:0][7:0] chars_q;
  logic [`CREDIT_W-1:0]          credit_q; // Free slots in the word queue
  logic                          take;     // Event consumed and acted on
  logic                          room;

  assign room = (len_q < len_max);

  // End of word waits for a credit, everything else pops at once
  assign word_push = evt_valid && (evt.kind == evt_eow) && !game_over &&
                     (credit_q != '0);
  assign evt_pop   = evt_valid &&
                     (game_over || (evt.kind != evt_eow) || (credit_q != '0));
  assign take      = evt_pop && !game_over;  // After game over just drain
  assign word_in   = '{len: len_q, chars: chars_q};

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      len_q     <= '0;
      chars_q   <= '0;
      credit_q  <= credit_init;
      game_over <= 1'b0;
    end else begin
      if (take) begin
        case (evt.kind)
          evt_letter: begin
            if (room) begin              // Extra letters dropped
              chars_q[len_q[idx_w-1:0]] <= evt.ch;
              len_q <= len_q + 1'b1;
            end
          end
          evt_eow: begin
            len_q   <= '0;
            chars_q <= '0;         // Slots cleared at word boundaries
          end
          evt_eog: begin
            len_q     <= '0;       // Partial word lost
            chars_q   <= '0;
            game_over <= 1'b1;     // Sticky until reset
          end
          default:    len_q <= len_q;
        endcase
      end
      case ({word_push, word_credit})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

endmodule

/* src/credit_fifo.sv */
`timescale 1ns/1ps

module credit_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     nRst,
  input  logic     push,
  input  payload_t din,
  output logic     credit_out,
  output logic     valid,
  output payload_t dout,
  input  logic     pop
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);
  localparam logic [ptr_w-1:0] ptr_last = ptr_w'(depth - 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] rd_ptr, wr_ptr;
  logic [cnt_w-1:0] count;
  logic             do_pop;

  assign valid  = (count != '0);
  assign dout   = mem[rd_ptr];   // Show-ahead head
  assign do_pop = pop && valid;  // Pop on empty ignored

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      count      <= '0;
      credit_out <= 1'b0;
    end else begin
      // Sender never pushes without a credit, so no full check
      if (push) wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit_out <= do_pop;      // Slot freed, one credit back
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= din;
  end

endmodule

/* src/keypad_fsm.sv */
`timescale 1ns/1ps

`include "keypad_defs.svh"

module keypad_fsm
  import keypad_pkg::*;
  import word_pkg::*;
(
  input  logic        clk,
  input  logic        nRst,
  input  key_code_t   key,
  input  logic        strobe,
  output logic        evt_push,
  output letter_evt_t evt,
  input  logic        evt_credit
);

  localparam logic [`CREDIT_W-1:0] credit_init = `EVT_FIFO_DEPTH;

  tap_state_t           state_q, state_d;
  key_code_t            last_q, last_d;   // Letter key being tapped
  letter_evt_t          evt_q, evt_d;     // Event waiting in done/emit
  logic [`CREDIT_W-1:0] credit_q;         // Free slots in the event queue
  logic                 ignored;
  logic                 is_letter;
  logic                 four;             // Key has four letters
  logic [7:0]           pend_char;

  // First letter on a key, zero for anything else
  function automatic logic [7:0] letter_base(key_code_t k);
    case (k)
      8'b1000_0100: letter_base = "A"; // R0C1
      8'b1000_0010: letter_base = "D"; // R0C2
      8'b0100_1000: letter_base = "G"; // R1C0
      8'b0100_0100: letter_base = "J"; // R1C1
      8'b0100_0010: letter_base = "M"; // R1C2
      key_pqrs:     letter_base = "P";
      8'b0010_0100: letter_base = "T"; // R2C1
      key_wxyz:     letter_base = "W";
      default:      letter_base = 8'd0;
    endcase
  endfunction

  // Offset from the base letter
  function automatic logic [1:0] tap_index(tap_state_t s);
    case (s)
      tap_1:   tap_index = 2'd1;
      tap_2:   tap_index = 2'd2;
      tap_3:   tap_index = 2'd3;
      default: tap_index = 2'd0;
    endcase
  endfunction

  // Repeat of the same key
  function automatic tap_state_t next_tap(tap_state_t s, logic four_letters);
    case (s)
      tap_0:   next_tap = tap_1;
      tap_1:   next_tap = tap_2;
      tap_2:   next_tap = four_letters ? tap_3 : tap_0;
      default: next_tap = tap_0; // Wrap after the last letter
    endcase
  endfunction

  assign ignored = (key == key_ign_r0c0) || (key == key_ign_r0c3) ||
                   (key == key_ign_r1c3) || (key == key_ign_r3c3);
  assign is_letter = (letter_base(key) != 8'd0);
  assign four      = (key == key_pqrs) || (key == key_wxyz);
  assign pend_char = letter_base(last_q) + {6'd0, tap_index(state_q)};

  // Push only with a credit in hand
  assign evt_push = (state_q == tap_emit) && (credit_q != '0);
  assign evt      = evt_q;

  always_comb begin
    state_d = state_q;
    last_d  = last_q;
    evt_d   = evt_q;
    case (state_q)
      tap_done: state_d = tap_emit;
      tap_emit: begin
        if (evt_push) state_d = tap_idle; // Strobes dropped while stalled
      end
      default: begin
        if (strobe && !ignored) begin
          if (key == key_clear) begin
            state_d = tap_idle;             // Drop pending letter
          end else if (key == key_submit_letter) begin
            if (state_q != tap_idle) begin  // Needs a pending letter
              state_d = tap_done;
              evt_d   = '{kind: evt_letter, ch: pend_char};
            end
          end else if (key == key_submit_word) begin
            state_d = tap_emit;
            evt_d   = '{kind: evt_eow, ch: 8'd0};
          end else if (key == key_game_end) begin
            state_d = tap_emit;             // Pending letter lost
            evt_d   = '{kind: evt_eog, ch: 8'd0};
          end else if (is_letter) begin
            last_d = key;
            if ((state_q != tap_idle) && (key == last_q))
              state_d = next_tap(state_q, four);
            else
              state_d = tap_0;              // New key starts at its base
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state_q  <= tap_idle;
      credit_q <= credit_init;
    end else begin
      state_q <= state_d;
      case ({evt_push, evt_credit})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;      // Both or neither
      endcase
    end
  end

  // Tapped key and queued event
  always_ff @(posedge clk) begin
    last_q <= last_d;
    evt_q  <= evt_d;
  end

endmodule

/* src/key_debounce.sv */
`timescale 1ns/1ps

`include "keypad_defs.svh"

module key_debounce
  import keypad_pkg::*;
(
  input  logic      clk,
  input  logic      nRst,
  input  key_code_t raw_key,
  output key_code_t key,
  output logic      strobe
);

  localparam int cnt_w = $clog2(`DEBOUNCE_CYCLES);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`DEBOUNCE_CYCLES - 1);

  key_code_t        sample_q; // Previous raw sample
  key_code_t        stable_q; // Last accepted code
  logic [cnt_w-1:0] cnt_q;    // Cycles the sample has held, minus one
  logic             same;     // Raw matches previous sample
  logic             settle;   // Sample just became stable and is new

  assign same   = (raw_key == sample_q);
  assign settle = same && (cnt_q == cnt_last) && (sample_q != stable_q);

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      sample_q <= '0;
      stable_q <= '0;
      cnt_q    <= '0;
      strobe   <= 1'b0;
    end else begin
      sample_q <= raw_key;
      if (!same) begin
        cnt_q <= '0;                 // Glitch or new code restarts the run
      end else if (cnt_q != cnt_last) begin
        cnt_q <= cnt_q + 1'b1;       // Saturates once stable
      end

      if (settle) begin
        stable_q <= sample_q;
      end
      // Release settles too but only a press strobes
      strobe <= settle && (sample_q != '0);
    end
  end

  assign key = stable_q; // Holds the new code in the strobe cycle

endmodule

/* src/word_pkg.sv */
`include "keypad_defs.svh"

package word_pkg;

  // Kinds of event between decoder and assembler
  typedef enum logic [1:0] {
    evt_letter = 2'd0, // Append ch to the word
    evt_eow    = 2'd1, // Close the word
    evt_eog    = 2'd2  // Game over
  } evt_kind_t;

  // One queue entry, ch only meaningful for letters
  typedef struct packed {
    evt_kind_t  kind;
    logic [7:0] ch;  // ASCII
  } letter_evt_t;

  // Finished word
  // chars[0] holds the first letter
  // Slots at and above len are zero
  typedef struct packed {
    logic [3:0]                        len;
    logic [`MAX_WORD_LEN-1:0][7:0]     chars;
  } word_t;

  // Length 0 is a legal record, an empty word

endpackage

/* src/keypad_pkg.sv */
package keypad_pkg;

  // One-hot row and column, row 0 and column 0 in the top bit
  typedef struct packed {
    logic [3:0] row;
    logic [3:0] col;
  } key_code_t;

  // Control keys
  localparam key_code_t key_submit_letter = '{row: 4'b0001, col: 4'b1000}; // R3C0
  localparam key_code_t key_clear         = '{row: 4'b0001, col: 4'b0100}; // R3C1
  localparam key_code_t key_submit_word   = '{row: 4'b0001, col: 4'b0010}; // R3C2
  localparam key_code_t key_game_end      = '{row: 4'b0010, col: 4'b0001}; // R2C3

  // Keys with no function
  localparam key_code_t key_ign_r0c0 = '{row: 4'b1000, col: 4'b1000};
  localparam key_code_t key_ign_r0c3 = '{row: 4'b1000, col: 4'b0001};
  localparam key_code_t key_ign_r1c3 = '{row: 4'b0100, col: 4'b0001};
  localparam key_code_t key_ign_r3c3 = '{row: 4'b0001, col: 4'b0001};

  // Letter keys with four letters, all others carry three
  localparam key_code_t key_pqrs = '{row: 4'b0010, col: 4'b1000}; // R2C0
  localparam key_code_t key_wxyz = '{row: 4'b0010, col: 4'b0010}; // R2C2

  // Multi-tap decoder states
  typedef enum logic [2:0] {
    tap_idle = 3'd0, // No letter pending
    tap_0    = 3'd1, // Base letter
    tap_1    = 3'd2,
    tap_2    = 3'd3,
    tap_3    = 3'd4, // Four-letter keys only
    tap_done = 3'd5, // Letter latched, one cycle
    tap_emit = 3'd6  // Waiting on a credit to push
  } tap_state_t;

endpackage

/* src/keypad_defs.svh */
`ifndef KEYPAD_DEFS_SVH
`define KEYPAD_DEFS_SVH

// Debounce
// Consecutive equal samples before a raw code counts as stable
`define DEBOUNCE_CYCLES 4

// Queue depths
`define EVT_FIFO_DEPTH 4  // Event queue, also decoder start credit
`define WORD_FIFO_DEPTH 2 // Word queue, also assembler start credit

// Credit counters must hold the largest depth
`define CREDIT_W 3

// Word records
// Letters beyond this are dropped by the assembler
`define MAX_WORD_LEN 8

// Length field of a word record is 4 bits wide,
// so MAX_WORD_LEN stays at or below 15
// MAX_WORD_LEN is a power of two so the slot index
// is the low bits of the length

`endif
